/* logic/dma_pkg.sv */
`default_nettype none

package dma_pkg;

   // master port request, held until ack
   typedef struct packed {
      logic        cyc;
      logic        we;
      logic [31:0] adr;   // byte address
      logic [31:0] dat;   // write data
   } bus_req_t;

   typedef struct packed {
      logic        ack;
      logic [31:0] dat;   // read data
   } bus_rsp_t;

   localparam int CTL_CNT_W = 16;   // word count field of the control word

   // one copy job from the descriptor controller to the mover
   typedef struct packed {
      logic [31:0]          src;
      logic [31:0]          dst;
      logic [CTL_CNT_W-1:0] cnt;   // words to copy
   } job_t;

   localparam int WORD_BYTES = 4;

   // descriptor layout, one word each
   localparam int DESC_WORDS = 4;
   localparam int DW_NEXT    = 0;   // next descriptor address
   localparam int DW_SRC     = 1;
   localparam int DW_DST     = 2;
   localparam int DW_CTL     = 3;   // control, status goes back here

   // control word bits
   localparam int CTL_CHAIN = 16;   // follow next pointer
   localparam int CTL_INT   = 17;   // interrupt on completion
   localparam int CTL_WB    = 18;   // write status back
   localparam int ST_DONE   = 31;   // set in the written-back status

   // host register indices
   localparam logic [1:0] REG_NDAR = 2'd0;
   localparam logic [1:0] REG_CSR  = 2'd1;
   localparam logic [1:0] REG_DAR  = 2'd2;   // read only

   // csr bits
   localparam int CSR_EN   = 0;
   localparam int CSR_INT  = 1;   // write 1 to clear
   localparam int CSR_BUSY = 2;   // read only

endpackage

`default_nettype wire

/* logic/dma_regs.sv */
`default_nettype none

module dma_regs (
   input  wire         wb_clk_i,
   input  wire         wb_rst_i,
   input  wire         reg_we_i,
   input  wire         reg_re_i,
   input  wire  [1:0]  reg_adr_i,
   input  wire  [31:0] reg_dat_i,
   output logic [31:0] reg_dat_o,
   output logic [31:2] ndar_o,
   output logic        ndar_dirty_o,
   output logic        enable_o,
   input  wire         ndar_take_i,
   input  wire         job_int_i,
   input  wire         dar_set_i,
   input  wire  [31:0] dar_i,
   input  wire         busy_i,
   output logic        int_o
);
   import dma_pkg::*;

   logic [31:2] ndar_r;    // word address of the next descriptor
   logic        dirty_r;
   logic        enable_r;
   logic        int_r;
   logic [31:0] dar_r;     // last completed descriptor
   logic        ndar_wr;
   logic        csr_wr;
   logic [31:0] csr_rd;

   assign ndar_wr = reg_we_i && (reg_adr_i == REG_NDAR);
   assign csr_wr  = reg_we_i && (reg_adr_i == REG_CSR);

   always_ff @(posedge wb_clk_i) begin
      if (ndar_wr) begin
         ndar_r <= reg_dat_i[31:2];
      end
   end

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         dirty_r  <= 1'b0;
         enable_r <= 1'b0;
         int_r    <= 1'b0;
         dar_r    <= '0;
      end else begin
         if (ndar_wr) begin
            dirty_r <= 1'b1;   // a new address beats a take
         end else if (ndar_take_i) begin
            dirty_r <= 1'b0;
         end
         if (csr_wr) begin
            enable_r <= reg_dat_i[CSR_EN];
         end
         if (job_int_i) begin
            int_r <= 1'b1;     // set wins over host clear
         end else if (csr_wr && reg_dat_i[CSR_INT]) begin
            int_r <= 1'b0;
         end
         if (dar_set_i) begin
            dar_r <= dar_i;
         end
      end
   end

   always_comb begin
      csr_rd           = '0;
      csr_rd[CSR_EN]   = enable_r;
      csr_rd[CSR_INT]  = int_r;
      csr_rd[CSR_BUSY] = busy_i;
   end

   always_ff @(posedge wb_clk_i) begin
      if (reg_re_i) begin
         case (reg_adr_i)
            REG_NDAR: reg_dat_o <= {ndar_r, 2'b00};
            REG_CSR:  reg_dat_o <= csr_rd;
            REG_DAR:  reg_dat_o <= dar_r;
            default:  reg_dat_o <= '0;
         endcase
      end
   end

   assign ndar_o       = ndar_r;
   assign ndar_dirty_o = dirty_r;
   assign enable_o     = enable_r;
   assign int_o        = int_r;

endmodule

`default_nettype wire

/* logic/dma_desc_ctrl.sv */
`default_nettype none

module dma_desc_ctrl #(
   parameter int ADDR_W = 32
) (
   input  wire                      wb_clk_i,
   input  wire                      wb_rst_i,
   input  wire  [31:2]              ndar_i,
   input  wire                      ndar_dirty_i,
   input  wire                      enable_i,
   output logic                     ndar_take_o,
   output logic                     job_int_o,
   output logic                     dar_set_o,
   output logic [31:0]              dar_o,
   output logic                     busy_o,
   output logic                     start_o,
   output dma_pkg::job_t            job_o,
   input  wire                      done_i,
   output dma_pkg::bus_req_t        bus_req_o,
   input  wire dma_pkg::bus_rsp_t   bus_rsp_i
);
   import dma_pkg::*;

   localparam int WC_W = $clog2(DESC_WORDS);

   typedef enum logic [2:0] {
      S_IDLE,
      S_FETCH,    // fetch with the mover idle
      S_HAND,     // start strobe
      S_PRE,      // prefetch while the mover copies
      S_WAIT,
      S_WB,
      S_DONE
   } state_t;

   state_t            state;
   logic [WC_W-1:0]   wcnt;       // descriptor word being fetched
   logic [ADDR_W-1:0] fa_r;       // descriptor under fetch
   logic              mv_done;    // done seen but not yet serviced
   logic              fetching;
   logic              last_word;
   logic              ack;
   logic              take;
   logic              chain_go;
   logic [ADDR_W-1:0] ndar_adr;

   // prefetched slot
   logic [ADDR_W-1:0] nxt_adr;
   logic [ADDR_W-1:0] nxt_next;
   job_t              nxt_job;
   logic [31:0]       nxt_ctl;

   // running slot
   logic [ADDR_W-1:0] cur_adr;
   logic [31:0]       cur_ctl;

   assign ack       = bus_rsp_i.ack;   // arbiter only acks the owner
   assign fetching  = (state == S_FETCH) || (state == S_PRE);
   assign last_word = (wcnt == WC_W'(DESC_WORDS - 1));
   assign chain_go  = cur_ctl[CTL_CHAIN];
   assign ndar_adr  = {ndar_i[ADDR_W-1:2], 2'b00};

   // a host address is taken from idle, or at the end of an unchained job
   assign take = enable_i && ndar_dirty_i &&
                 ((state == S_IDLE) || ((state == S_DONE) && !chain_go));

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state   <= S_IDLE;
         wcnt    <= '0;
         mv_done <= 1'b0;
      end else begin
         if (done_i) begin
            mv_done <= 1'b1;
         end else if (state == S_HAND) begin
            mv_done <= 1'b0;
         end
         if (fetching && ack) begin
            wcnt <= wcnt + 1'b1;   // wraps back to word 0
         end
         case (state)
            S_IDLE: begin
               if (take) begin
                  state <= S_FETCH;
               end
            end
            S_FETCH: begin
               if (ack && last_word) begin
                  state <= S_HAND;
               end
            end
            S_HAND: begin
               state <= nxt_ctl[CTL_CHAIN] ? S_PRE : S_WAIT;
            end
            S_PRE: begin
               if (ack && last_word) begin
                  state <= S_WAIT;
               end
            end
            S_WAIT: begin
               if (mv_done || done_i) begin
                  state <= cur_ctl[CTL_WB] ? S_WB : S_DONE;
               end
            end
            S_WB: begin
               if (ack) begin
                  state <= S_DONE;
               end
            end
            S_DONE: begin
               if (chain_go) begin
                  state <= S_HAND;     // prefetched job is ready
               end else if (take) begin
                  state <= S_FETCH;
               end else begin
                  state <= S_IDLE;
               end
            end
            default: state <= S_IDLE;
         endcase
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if (take) begin
         fa_r <= ndar_adr;
      end else if (state == S_HAND) begin
         fa_r <= nxt_next;     // prefetch target
      end
      if (fetching && ack) begin
         case (int'(wcnt))
            DW_NEXT: begin
               nxt_adr  <= fa_r;
               nxt_next <= {bus_rsp_i.dat[ADDR_W-1:2], 2'b00};
            end
            DW_SRC: nxt_job.src <= bus_rsp_i.dat;
            DW_DST: nxt_job.dst <= bus_rsp_i.dat;
            default: begin
               nxt_ctl     <= bus_rsp_i.dat;
               nxt_job.cnt <= bus_rsp_i.dat[CTL_CNT_W-1:0];
            end
         endcase
      end
      if (state == S_HAND) begin
         cur_adr <= nxt_adr;
         cur_ctl <= nxt_ctl;
      end
   end

   always_comb begin
      bus_req_o = '0;
      if (fetching) begin
         bus_req_o.cyc = 1'b1;
         bus_req_o.adr = 32'(fa_r + ADDR_W'(int'(wcnt) * WORD_BYTES));
      end else if (state == S_WB) begin
         bus_req_o.cyc = 1'b1;
         bus_req_o.we  = 1'b1;
         bus_req_o.adr = 32'(cur_adr + ADDR_W'(DW_CTL * WORD_BYTES));
         bus_req_o.dat = cur_ctl | (32'd1 << ST_DONE);
      end
   end

   assign start_o     = (state == S_HAND);
   assign job_o       = nxt_job;
   assign dar_set_o   = (state == S_DONE);
   assign job_int_o   = (state == S_DONE) && cur_ctl[CTL_INT];
   assign dar_o       = 32'(cur_adr);
   assign busy_o      = (state != S_IDLE);
   assign ndar_take_o = take;

endmodule

`default_nettype wire

/* logic/dma_mover.sv */
`default_nettype none

module dma_mover #(
   parameter int ADDR_W = 32
) (
   input  wire                      wb_clk_i,
   input  wire                      wb_rst_i,
   input  wire                      start_i,
   input  wire dma_pkg::job_t       job_i,
   output logic                     done_o,
   output dma_pkg::bus_req_t        bus_req_o,
   input  wire dma_pkg::bus_rsp_t   bus_rsp_i
);
   import dma_pkg::*;

   typedef enum logic [1:0] {
      M_IDLE,
      M_RD,
      M_WR
   } mstate_t;

   mstate_t              state;
   logic [ADDR_W-1:0]    src_r;
   logic [ADDR_W-1:0]    dst_r;
   logic [CTL_CNT_W-1:0] cnt_r;    // words left
   logic [31:0]          hold_r;   // word in transit
   logic                 ack;

   assign ack = bus_rsp_i.ack;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         state  <= M_IDLE;
         done_o <= 1'b0;
      end else begin
         done_o <= 1'b0;
         case (state)
            M_IDLE: begin
               if (start_i) begin
                  if (job_i.cnt == '0) begin
                     done_o <= 1'b1;   // empty job
                  end else begin
                     state <= M_RD;
                  end
               end
            end
            M_RD: begin
               if (ack) begin
                  state <= M_WR;
               end
            end
            M_WR: begin
               if (ack) begin
                  if (cnt_r == CTL_CNT_W'(1)) begin
                     state  <= M_IDLE;
                     done_o <= 1'b1;
                  end else begin
                     state <= M_RD;
                  end
               end
            end
            default: state <= M_IDLE;
         endcase
      end
   end

   always_ff @(posedge wb_clk_i) begin
      if ((state == M_IDLE) && start_i) begin
         src_r <= job_i.src[ADDR_W-1:0];
         dst_r <= job_i.dst[ADDR_W-1:0];
         cnt_r <= job_i.cnt;
      end
      if ((state == M_RD) && ack) begin
         hold_r <= bus_rsp_i.dat;
         src_r  <= src_r + ADDR_W'(WORD_BYTES);
      end
      if ((state == M_WR) && ack) begin
         dst_r <= dst_r + ADDR_W'(WORD_BYTES);
         cnt_r <= cnt_r - 1'b1;
      end
   end

   always_comb begin
      bus_req_o.cyc = (state != M_IDLE);
      bus_req_o.we  = (state == M_WR);
      bus_req_o.adr = 32'((state == M_WR) ? dst_r : src_r);
      bus_req_o.dat = hold_r;
   end

endmodule

`default_nettype wire

/* logic/dma_bus_arb.sv */
`default_nettype none

module dma_bus_arb #(
   parameter int ADDR_W = 32
) (
   input  wire                      wb_clk_i,
   input  wire                      wb_rst_i,
   input  wire dma_pkg::bus_req_t   req_a_i,
   input  wire dma_pkg::bus_req_t   req_b_i,
   output dma_pkg::bus_rsp_t        rsp_a_o,
   output dma_pkg::bus_rsp_t        rsp_b_o,
   output dma_pkg::bus_req_t        bus_req_o,
   input  wire dma_pkg::bus_rsp_t   bus_rsp_i
);
   import dma_pkg::*;

   localparam logic [32:0] ADR_LIM  = 33'd1 << ADDR_W;
   localparam logic [31:0] ADR_MASK = 32'(ADR_LIM - 33'd1);

   logic     last_b;    // b owned the last finished transfer
   logic     locked;    // transfer in progress, grant frozen
   logic     owner_b;
   logic     gnt_b;
   bus_req_t sel;

   always_comb begin
      if (locked) begin
         gnt_b = owner_b;
      end else if (req_a_i.cyc && req_b_i.cyc) begin
         gnt_b = ~last_b;   // round robin
      end else begin
         gnt_b = req_b_i.cyc;
      end
   end

   assign sel = gnt_b ? req_b_i : req_a_i;

   always_ff @(posedge wb_clk_i or posedge wb_rst_i) begin
      if (wb_rst_i) begin
         last_b  <= 1'b0;
         locked  <= 1'b0;
         owner_b <= 1'b0;
      end else begin
         locked  <= sel.cyc && !bus_rsp_i.ack;
         owner_b <= gnt_b;
         if (sel.cyc && bus_rsp_i.ack) begin
            last_b <= gnt_b;
         end
      end
   end

   always_comb begin
      bus_req_o     = sel;
      bus_req_o.adr = sel.adr & ADR_MASK;
      rsp_a_o.ack   = bus_rsp_i.ack && !gnt_b && req_a_i.cyc;
      rsp_a_o.dat   = bus_rsp_i.dat;
      rsp_b_o.ack   = bus_rsp_i.ack && gnt_b && req_b_i.cyc;
      rsp_b_o.dat   = bus_rsp_i.dat;
   end

endmodule

`default_nettype wire

/* logic/dma_top.sv */
`default_nettype none

module dma_top #(
   parameter int ADDR_W = 32
) (
   input  wire                      wb_clk_i,
   input  wire                      wb_rst_i,
   input  wire                      reg_we_i,
   input  wire                      reg_re_i,
   input  wire  [1:0]               reg_adr_i,
   input  wire  [31:0]              reg_dat_i,
   output logic [31:0]              reg_dat_o,
   output dma_pkg::bus_req_t        wbm_req_o,
   input  wire dma_pkg::bus_rsp_t   wbm_rsp_i,
   output logic                     busy_o,
   output logic                     wb_int_o
);
   import dma_pkg::*;

   logic [31:2] ndar;
   logic        ndar_dirty;
   logic        enable;
   logic        ndar_take;
   logic        job_int;
   logic        dar_set;
   logic [31:0] dar;
   logic        start;
   logic        done;
   job_t        job;
   bus_req_t    ctrl_req;
   bus_rsp_t    ctrl_rsp;
   bus_req_t    mov_req;
   bus_rsp_t    mov_rsp;

   dma_regs u_regs (
      .wb_clk_i     (wb_clk_i),
      .wb_rst_i     (wb_rst_i),
      .reg_we_i     (reg_we_i),
      .reg_re_i     (reg_re_i),
      .reg_adr_i    (reg_adr_i),
      .reg_dat_i    (reg_dat_i),
      .reg_dat_o    (reg_dat_o),
      .ndar_o       (ndar),
      .ndar_dirty_o (ndar_dirty),
      .enable_o     (enable),
      .ndar_take_i  (ndar_take),
      .job_int_i    (job_int),
      .dar_set_i    (dar_set),
      .dar_i        (dar),
      .busy_i       (busy_o),
      .int_o        (wb_int_o)
   );

   dma_desc_ctrl #(.ADDR_W(ADDR_W)) u_ctrl (
      .wb_clk_i     (wb_clk_i),
      .wb_rst_i     (wb_rst_i),
      .ndar_i       (ndar),
      .ndar_dirty_i (ndar_dirty),
      .enable_i     (enable),
      .ndar_take_o  (ndar_take),
      .job_int_o    (job_int),
      .dar_set_o    (dar_set),
      .dar_o        (dar),
      .busy_o       (busy_o),
      .start_o      (start),
      .job_o        (job),
      .done_i       (done),
      .bus_req_o    (ctrl_req),
      .bus_rsp_i    (ctrl_rsp)
   );

   dma_mover #(.ADDR_W(ADDR_W)) u_mover (
      .wb_clk_i  (wb_clk_i),
      .wb_rst_i  (wb_rst_i),
      .start_i   (start),
      .job_i     (job),
      .done_o    (done),
      .bus_req_o (mov_req),
      .bus_rsp_i (mov_rsp)
   );

   // controller is master a, mover is master b
   dma_bus_arb #(.ADDR_W(ADDR_W)) u_arb (
      .wb_clk_i  (wb_clk_i),
      .wb_rst_i  (wb_rst_i),
      .req_a_i   (ctrl_req),
      .req_b_i   (mov_req),
      .rsp_a_o   (ctrl_rsp),
      .rsp_b_o   (mov_rsp),
      .bus_req_o (wbm_req_o),
      .bus_rsp_i (wbm_rsp_i)
   );

endmodule

`default_nettype wire

/* sim/dma_props.sv */
`default_nettype none

module dma_props (
   input wire                    clk_i,
   input wire                    rst_i,
   input wire dma_pkg::bus_rsp_t rsp_a_i,
   input wire dma_pkg::bus_rsp_t rsp_b_i,
   input wire dma_pkg::bus_req_t bus_req_i,
   input wire dma_pkg::bus_rsp_t bus_rsp_i,
   input wire                    start_i,
   input wire                    mv_busy_i
);

   int unsigned fail_cnt = 0;

   // address, we and data frozen while waiting for ack
   hold_until_ack: assert property (
      @(posedge clk_i) disable iff (rst_i)
      (bus_req_i.cyc && !bus_rsp_i.ack) |=> (bus_req_i.cyc && $stable(bus_req_i))
   ) else begin
      fail_cnt++;
      $error("bus request changed or dropped before its acknowledge");
   end

   one_owner: assert property (
      @(posedge clk_i) disable iff (rst_i)
      !(rsp_a_i.ack && rsp_b_i.ack)
   ) else begin
      fail_cnt++;
      $error("acknowledge routed to both masters");
   end

   start_when_idle: assert property (
      @(posedge clk_i) disable iff (rst_i)
      start_i |-> !mv_busy_i
   ) else begin
      fail_cnt++;
      $error("mover started while still copying");
   end

   // cyc must be low while reset is held
   quiet_in_reset: assert property (
      @(posedge clk_i) rst_i |-> !bus_req_i.cyc
   ) else begin
      fail_cnt++;
      $error("bus cycle active during reset");
   end

endmodule

// mover side of the arbiter, held while the controller owns the bus
bind dma_bus_arb dma_props props_arb (
   .clk_i     (wb_clk_i),
   .rst_i     (wb_rst_i),
   .rsp_a_i   (rsp_a_o),
   .rsp_b_i   (rsp_b_o),
   .bus_req_i (req_b_i),
   .bus_rsp_i (rsp_b_o),
   .start_i   (1'b0),
   .mv_busy_i (1'b0)
);

bind dma_top dma_props props_top (
   .clk_i     (wb_clk_i),
   .rst_i     (wb_rst_i),
   .rsp_a_i   (ctrl_rsp),
   .rsp_b_i   (mov_rsp),
   .bus_req_i (wbm_req_o),
   .bus_rsp_i (wbm_rsp_i),
   .start_i   (start),
   .mv_busy_i (mov_req.cyc)
);

`default_nettype wire

/* sim/dma_tb.sv */
`default_nettype none

module dma_tb;
   import dma_pkg::*;

   localparam int CNT_A = 8;
   localparam int CNT_B = 5;
   localparam int CNT_C = 0;
   localparam int CNT_D = 12;
   localparam int WATCHDOG_CYC = 200 * (CNT_A + CNT_B + CNT_C + CNT_D) + 2000;
   localparam logic [31:0] DESC_A   = 32'h0000_0000;
   localparam logic [31:0] DESC_B   = 32'h0000_0040;
   localparam logic [31:0] DESC_C   = 32'h0000_0080;
   localparam logic [31:0] DESC_D   = 32'h0000_00c0;
   localparam logic [31:0] DESC_TOP = 32'h0000_0400;   // descriptors live below this

   logic        wb_clk_i;
   logic        wb_rst_i;
   logic        reg_we_i;
   logic        reg_re_i;
   logic [1:0]  reg_adr_i;
   logic [31:0] reg_dat_i;
   logic [31:0] reg_dat_o;
   bus_req_t    wbm_req_o;
   bus_rsp_t    wbm_rsp_i;
   logic        busy_o;
   logic        wb_int_o;

   logic [31:0] mem [0:1023];       // memory behind the master port
   logic [31:0] exp_mem [0:1023];   // model memory
   logic [31:0] lcg_state;
   logic        ack_slow;           // ack delay 2..3 instead of 0..3
   logic        pending;
   int          wait_left;
   logic [9:0]  idx;
   logic        in_copy;
   int          overlap_cnt;
   int          errors;
   int          checks;
   int          prop_errs;
   int          lat;
   int          quiet_cnt;
   logic [31:0] rd;

   dma_top #(.ADDR_W(32)) DUT (
      .wb_clk_i  (wb_clk_i),
      .wb_rst_i  (wb_rst_i),
      .reg_we_i  (reg_we_i),
      .reg_re_i  (reg_re_i),
      .reg_adr_i (reg_adr_i),
      .reg_dat_i (reg_dat_i),
      .reg_dat_o (reg_dat_o),
      .wbm_req_o (wbm_req_o),
      .wbm_rsp_i (wbm_rsp_i),
      .busy_o    (busy_o),
      .wb_int_o  (wb_int_o)
   );

   initial wb_clk_i = 1'b0;
   always #4 wb_clk_i = ~wb_clk_i;

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   function automatic logic [31:0] ctl_word(input int cnt, input logic chain,
                                            input logic irq, input logic wb);
      logic [31:0] c;
      c = 32'(cnt) & 32'h0000_ffff;
      c[CTL_CHAIN] = chain;
      c[CTL_INT]   = irq;
      c[CTL_WB]    = wb;
      return c;
   endfunction

   task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      assert (act === exp) else begin
         errors++;
         $display("Fail %s: expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic fill_mem();
      for (int i = 0; i < 1024; i++) begin
         if (i >= 256 && i < 512) begin
            lcg_state = lcg_next(lcg_state);   // source data
            mem[10'(i)] = lcg_state;
         end else begin
            mem[10'(i)] = 32'hc0de_0000 | 32'(i);
         end
         exp_mem[10'(i)] = mem[10'(i)];
      end
   endtask

   // descriptor in memory and in the model
   task automatic put_desc(input logic [31:0] adr, input logic [31:0] nxt,
                           input logic [31:0] src, input logic [31:0] dst,
                           input logic [31:0] ctl);
      logic [9:0] w;
      w = adr[11:2];
      mem[w]              = nxt;
      mem[w + 10'd1]      = src;
      mem[w + 10'd2]      = dst;
      mem[w + 10'd3]      = ctl;
      exp_mem[w]          = nxt;
      exp_mem[w + 10'd1]  = src;
      exp_mem[w + 10'd2]  = dst;
      exp_mem[w + 10'd3]  = ctl;
   endtask

   // copy and status that one finished job leaves in the model
   task automatic expect_job(input logic [31:0] adr);
      logic [9:0]  w;
      logic [31:0] src;
      logic [31:0] dst;
      logic [31:0] ctl;
      w   = adr[11:2];
      src = exp_mem[w + 10'd1];
      dst = exp_mem[w + 10'd2];
      ctl = exp_mem[w + 10'd3];
      for (int i = 0; i < int'(ctl[15:0]); i++) begin
         exp_mem[dst[11:2] + 10'(i)] = exp_mem[src[11:2] + 10'(i)];
      end
      if (ctl[CTL_WB]) begin
         exp_mem[w + 10'd3][ST_DONE] = 1'b1;
      end
   endtask

   task automatic compare_mem(input string name);
      for (int i = 0; i < 1024; i++) begin
         check_val($sformatf("%s mem[%0d]", name, i), exp_mem[10'(i)], mem[10'(i)]);
      end
   endtask

   task automatic reg_write(input logic [1:0] adr, input logic [31:0] dat);
      @(negedge wb_clk_i);
      reg_we_i  = 1'b1;
      reg_adr_i = adr;
      reg_dat_i = dat;
      @(negedge wb_clk_i);
      reg_we_i  = 1'b0;
   endtask

   task automatic reg_read(input logic [1:0] adr, output logic [31:0] dat);
      @(negedge wb_clk_i);
      reg_re_i  = 1'b1;
      reg_adr_i = adr;
      @(negedge wb_clk_i);
      reg_re_i  = 1'b0;
      dat       = reg_dat_o;   // registered, one cycle after the strobe
   endtask

   task automatic wait_cyc(input string name, output int n);
      n = 0;
      while (!wbm_req_o.cyc && n < 50) begin
         @(negedge wb_clk_i);
         n++;
      end
      if (!wbm_req_o.cyc) begin
         errors++;
         $display("%s: no bus request appeared after the start", name);
      end
   endtask

   task automatic wait_idle(input string name);
      int n;
      n = 0;
      while (busy_o && n < WATCHDOG_CYC) begin
         @(negedge wb_clk_i);
         n++;
      end
      if (busy_o) begin
         errors++;
         $display("%s: busy never dropped", name);
      end
   endtask

   // memory slave, answers after a random wait
   always @(negedge wb_clk_i) begin
      wbm_rsp_i.ack = 1'b0;
      if (!wb_rst_i && wbm_req_o.cyc) begin
         if (!pending) begin
            pending   = 1'b1;
            lcg_state = lcg_next(lcg_state);
            wait_left = ack_slow ? 2 + int'(lcg_state[16]) : int'(lcg_state[17:16]);
         end
         if (wait_left == 0) begin
            pending = 1'b0;
            idx     = wbm_req_o.adr[11:2];
            if (wbm_req_o.we) begin
               mem[idx] = wbm_req_o.dat;
            end
            wbm_rsp_i.ack = 1'b1;
            wbm_rsp_i.dat = mem[idx];
         end else begin
            wait_left--;
         end
      end
   end

   // descriptor reads seen while the mover holds a job
   always @(negedge wb_clk_i) begin
      if (DUT.start) begin
         in_copy = 1'b1;
      end
      if (in_copy && wbm_req_o.cyc && !wbm_req_o.we && wbm_req_o.adr < DESC_TOP) begin
         overlap_cnt++;
      end
      if (DUT.done) begin
         in_copy = 1'b0;
      end
   end

   initial begin
      repeat (WATCHDOG_CYC) @(posedge wb_clk_i);
      $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYC);
      $display("=== FAIL ===");
      $finish;
   end

   initial begin
      wb_rst_i    = 1'b1;
      reg_we_i    = 1'b0;
      reg_re_i    = 1'b0;
      reg_adr_i   = '0;
      reg_dat_i   = '0;
      wbm_rsp_i   = '0;
      lcg_state   = 32'he3ae_1cdb;
      ack_slow    = 1'b0;
      pending     = 1'b0;
      wait_left   = 0;
      in_copy     = 1'b0;
      overlap_cnt = 0;
      errors      = 0;
      checks      = 0;
      quiet_cnt   = 0;
      fill_mem();
      put_desc(DESC_A, DESC_A, 32'h400, 32'h800, ctl_word(CNT_A, 1'b0, 1'b0, 1'b1));
      put_desc(DESC_B, DESC_C, 32'h500, 32'h900, ctl_word(CNT_B, 1'b1, 1'b0, 1'b1));
      put_desc(DESC_C, DESC_D, 32'h700, 32'ha00, ctl_word(CNT_C, 1'b1, 1'b0, 1'b0));
      put_desc(DESC_D, DESC_A, 32'h600, 32'hc00, ctl_word(CNT_D, 1'b0, 1'b1, 1'b1));
      repeat (8) @(posedge wb_clk_i);
      @(negedge wb_clk_i);
      wb_rst_i = 1'b0;
      check_val("reset_cyc", 32'd0, 32'(wbm_req_o.cyc));
      check_val("reset_busy", 32'd0, 32'(busy_o));
      check_val("reset_int", 32'd0, 32'(wb_int_o));

      // address loaded with enable clear must stay parked
      reg_write(REG_NDAR, DESC_A);
      repeat (20) begin
         @(negedge wb_clk_i);
         if (wbm_req_o.cyc || busy_o || wb_int_o) begin
            quiet_cnt++;
         end
      end
      check_val("disabled_quiet", 32'd0, 32'(quiet_cnt));
      reg_write(REG_CSR, 32'h1);
      wait_cyc("idle_start", lat);
      assert (lat <= 2) else begin
         errors++;
         $display("Fail idle_start: expected at most 2 cycles, actual %0d", lat);
      end
      wait_idle("single");
      expect_job(DESC_A);
      compare_mem("single");
      check_val("single_int", 32'd0, 32'(wb_int_o));

      // three linked jobs under a slow memory
      ack_slow = 1'b1;
      reg_write(REG_NDAR, DESC_B);
      wait_cyc("chain_start", lat);
      assert (lat <= 2) else begin
         errors++;
         $display("Fail chain_start: expected at most 2 cycles, actual %0d", lat);
      end
      wait_idle("chain");
      expect_job(DESC_B);
      expect_job(DESC_C);
      expect_job(DESC_D);
      compare_mem("chain");
      reg_read(REG_DAR, rd);
      check_val("chain_dar", DESC_D, rd);
      check_val("chain_int", 32'd1, 32'(wb_int_o));
      assert (overlap_cnt > 0) else begin
         errors++;
         $display("overlap: no descriptor fetch seen while the mover was copying");
      end

      reg_write(REG_CSR, 32'h3);
      check_val("int_clear", 32'd0, 32'(wb_int_o));
      reg_write(REG_CSR, 32'h3);
      check_val("int_clear_idle", 32'd0, 32'(wb_int_o));
      reg_read(REG_CSR, rd);
      check_val("csr_idle", 32'h1, rd);

      prop_errs = int'(DUT.props_top.fail_cnt) + int'(DUT.u_arb.props_arb.fail_cnt);
      $display("checks %0d, errors %0d, property failures %0d", checks, errors, prop_errs);
      if (errors == 0 && prop_errs == 0) begin
         $display("=== PASS ===");
      end else begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* all.f */
logic/dma_pkg.sv
logic/dma_regs.sv
logic/dma_desc_ctrl.sv
logic/dma_mover.sv
logic/dma_bus_arb.sv
logic/dma_top.sv
sim/dma_props.sv
sim/dma_tb.sv

/* run.sh */
#!/bin/sh
# build and run the DMA testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -j 0 --top-module dma_tb -f all.f &&
./obj_dir/Vdma_tb +verilator+error+limit+1000 | tee /dev/stderr |
   grep -x "=== PASS ===" > /dev/null &&
echo "run.sh: simulation passed" ||
{ echo "run.sh: simulation failed"; exit 1; }
